// File: Makefile
TOP := commit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

sim:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: commit.sv
`timescale 1ns/1ps

module commit (
    input  logic                  clk,
    input  logic                  reset,
    input  mips_pkg::exec_data_t  stage_slot1,
    input  mips_pkg::exec_data_t  stage_slot0,
    input  logic                  stage_full,
    input  logic                  first_cycle,
    input  mips_pkg::exec_data_t  checked1,
    input  mips_pkg::exec_data_t  checked0,
    input  logic                  exc_valid1,
    input  mips_pkg::exception_t  exc_data1,
    input  logic                  exc_valid0,
    input  mips_pkg::exception_t  exc_data0,
    input  logic [1:0]            size1,
    input  mips_pkg::word_t       wdata1,
    input  logic [1:0]            size0,
    input  mips_pkg::word_t       wdata0,
    input  mips_pkg::word_t       load_data,
    input  mips_pkg::word_t       dmem_rd,
    input  logic                  dmem_data_ok,
    output logic                  finish,
    output logic                  dmem_en,
    output logic                  dmem_wt,
    output mips_pkg::word_t       dmem_addr,
    output mips_pkg::word_t       dmem_wd,
    output logic [1:0]            dmem_size,
    output mips_pkg::decoded_op_t op_sel,
    output logic                  commit_valid,
    output mips_pkg::exec_data_t  out_slot1,
    output mips_pkg::exec_data_t  out_slot0,
    output logic                  exception_valid,
    output mips_pkg::exception_t  exception_data,
    output logic                  is_eret,
    output mips_pkg::word_t       redirect_pc
);
    import mips_pkg::*;

    logic       mem_slot1;
    logic       eret1;
    logic       eret0;
    logic       mask;
    logic       exc0_live;
    logic       mem_req;
    logic       req_out;
    word_t      load_value;
    exec_data_t merged1;
    exec_data_t merged0;

    // older slot owns the memory port when it is a memory op
    assign mem_slot1 = is_mem(stage_slot1.op);

    // younger slot is dropped behind an exception or eret
    assign eret1 = checked1.valid & (checked1.op == ERET);
    assign mask = exc_valid1 | eret1;
    assign eret0 = ~mask & checked0.valid & (checked0.op == ERET);
    assign exc0_live = ~mask & exc_valid0;

    // checked ops are nop on exception, so a faulting access never goes out
    assign mem_req = mem_slot1 ? is_mem(checked1.op) : (~mask & is_mem(checked0.op));
    assign dmem_en = stage_full & mem_req;
    assign op_sel = mem_slot1 ? checked1.op : checked0.op;
    assign dmem_wt = is_store(op_sel);
    assign dmem_addr = mem_slot1 ? stage_slot1.result : stage_slot0.result;
    assign dmem_wd = mem_slot1 ? wdata1 : wdata0;
    assign dmem_size = mem_slot1 ? size1 : size0;

    // request outstanding for the pair now held
    always_ff @(posedge clk) begin
        if (reset) begin
            req_out <= 1'b0;
        end else begin
            req_out <= dmem_en & ~finish;
        end
    end

    // data_ok seen in a first cycle belongs to the previous pair
    assign finish = first_cycle ? ~dmem_en : (~dmem_en | (dmem_data_ok & req_out));
    assign commit_valid = stage_full & finish;

    // whole words skip the lane extractor
    assign load_value = (op_sel == LW) ? dmem_rd : load_data;

    always_comb begin
        merged1 = checked1;
        merged0 = checked0;
        if (is_load(checked1.op)) begin
            merged1.result = load_value;
        end
        if (is_load(checked0.op)) begin
            merged0.result = load_value;
        end
    end

    assign out_slot1 = commit_valid ? merged1 : '0;
    assign out_slot0 = (commit_valid & ~mask) ? merged0 : '0;

    assign exception_valid = commit_valid & (exc_valid1 | exc0_live);
    assign exception_data = !commit_valid ? '0 :
                            exc_valid1    ? exc_data1 :
                            exc0_live     ? exc_data0 : '0;
    assign is_eret = commit_valid & (eret1 | eret0);

    always_comb begin
        if (exception_valid) begin
            redirect_pc = exception_data.pc;
        end else if (is_eret) begin
            redirect_pc = eret1 ? checked1.epc : checked0.epc;
        end else begin
            redirect_pc = '0;
        end
    end

endmodule

// File: commit_assert.sv
`timescale 1ns/1ps

module commit_assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 in_valid,
    input logic                 in_ready,
    input logic                 stage_full,
    input logic                 commit_valid,
    input logic                 exception_valid,
    input logic                 is_eret,
    input logic                 dmem_en,
    input logic                 dmem_data_ok,
    input logic                 exc_valid1,
    input mips_pkg::exec_data_t stage_slot1,
    input mips_pkg::exec_data_t out_slot0
);
    import mips_pkg::*;

    int   fail_count = 0;
    logic reset_seen = 1'b0;
    logic accept;

    assign accept = in_valid & in_ready;

    // first reset edge leaves state unknown until it has been applied once
    always @(posedge clk) begin
        if (reset) begin
            reset_seen <= 1'b1;
        end
    end

    // pair with no memory access commits in its first cycle
    assert property (@(posedge clk) disable iff (reset)
        $past(accept) && !dmem_en |-> commit_valid)
    else begin
        fail_count++;
        $error("pair without memory access did not commit one cycle after acceptance");
    end

    // memory pair waits one cycle for data_ok
    assert property (@(posedge clk) disable iff (reset)
        $past(accept) && dmem_en |-> !commit_valid)
    else begin
        fail_count++;
        $error("memory pair committed in its first cycle");
    end

    assert property (@(posedge clk) disable iff (reset)
        $past(accept, 2) && $past(dmem_en) |-> commit_valid)
    else begin
        fail_count++;
        $error("memory pair did not commit two cycles after acceptance");
    end

    // older slot held as eret, or faulting, drops the younger one
    assert property (@(posedge clk) disable iff (reset)
        commit_valid && (exc_valid1 || (stage_slot1.valid && stage_slot1.op == ERET))
            |-> out_slot0 == '0)
    else begin
        fail_count++;
        $error("younger slot not cleared behind an exception or eret");
    end

    assert property (@(posedge clk) disable iff (reset)
        dmem_en && !dmem_data_ok |-> !in_ready)
    else begin
        fail_count++;
        $error("stage ready while a memory access is outstanding");
    end

    assert property (@(posedge clk)
        reset_seen && reset |-> !stage_full && !commit_valid && !exception_valid
            && !is_eret && !dmem_en && !dmem_data_ok && in_ready)
    else begin
        fail_count++;
        $error("output active during reset");
    end

endmodule

bind commit_top commit_assert commit_assert_i (
    .clk, .reset, .in_valid, .in_ready, .stage_full, .commit_valid,
    .exception_valid, .is_eret, .dmem_en, .dmem_data_ok, .exc_valid1,
    .stage_slot1, .out_slot0
);

// File: commit_stage_reg.sv
`timescale 1ns/1ps

module commit_stage_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  mips_pkg::exec_data_t in_slot1,
    input  mips_pkg::exec_data_t in_slot0,
    input  logic                 finish,
    output logic                 in_ready,
    output mips_pkg::exec_data_t stage_slot1,
    output mips_pkg::exec_data_t stage_slot0,
    output logic                 stage_full,
    output logic                 first_cycle
);

    logic accept;

    // room when empty or the held pair leaves this cycle
    assign in_ready = ~stage_full | finish;
    assign accept = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_full <= 1'b0;
            first_cycle <= 1'b0;
        end else begin
            if (accept) begin
                stage_full <= 1'b1;
            end else if (finish) begin
                stage_full <= 1'b0;
            end
            first_cycle <= accept;
        end
    end

    // pair stays stable until commit finishes
    always_ff @(posedge clk) begin
        if (accept) begin
            stage_slot1 <= in_slot1;
            stage_slot0 <= in_slot0;
        end
    end

endmodule

// File: commit_tb.sv
`timescale 1ns/1ps

module commit_tb;
    import mips_pkg::*;

    localparam int RAM_WORDS = 256;
    localparam int WAIT_LIMIT = 50;
    localparam int CW = $bits(exec_data_t);

    typedef struct packed {
        exec_data_t s1;
        exec_data_t s0;
        logic       exc_v;
        exception_t exc;
        logic       eret;
        word_t      rpc;
    } commit_rec_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    exec_data_t  in_slot1;
    exec_data_t  in_slot0;
    logic [5:0]  ext_int;
    logic        timer_interrupt;
    logic        in_ready;
    logic        commit_valid;
    exec_data_t  out_slot1;
    exec_data_t  out_slot0;
    logic        exception_valid;
    exception_t  exception_data;
    logic        is_eret;
    word_t       redirect_pc;

    logic [7:0]  ref_mem [RAM_WORDS*4];
    commit_rec_t seen_q [$];
    commit_rec_t want_q [$];
    int          value_errors;
    int          timeout_errors;
    int          assert_errors;
    int unsigned seed;
    decoded_op_t store_ops [3] = '{SB, SH, SW};
    decoded_op_t load_ops [5] = '{LB, LBU, LH, LHU, LW};

    commit_top #(
        .RAM_WORDS(RAM_WORDS)
    ) commit_top_i (
        .clk, .reset, .in_valid, .in_slot1, .in_slot0, .ext_int, .timer_interrupt,
        .in_ready, .commit_valid, .out_slot1, .out_slot0, .exception_valid,
        .exception_data, .is_eret, .redirect_pc
    );

    always #2 clk = ~clk;

    function automatic commit_rec_t record(exec_data_t s1, exec_data_t s0, logic ev,
                                           exception_t exc, logic eret, word_t rpc);
        return {s1, s0, ev, exc, eret, rpc};
    endfunction

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            seen_q.push_back(record(out_slot1, out_slot0, exception_valid, exception_data,
                                    is_eret, redirect_pc));
        end
    end

    function automatic exec_data_t make_slot(decoded_op_t op, word_t pc, word_t result,
                                             word_t srcb);
        exec_data_t s;
        s = '0;
        s.valid = 1'b1;
        s.op = op;
        s.pc = pc;
        s.result = result;
        s.srcb = srcb;
        s.destreg = pc[6:2];
        s.regwrite = op inside {ALU, LW, LH, LHU, LB, LBU};
        s.epc = pc + 32'h1000;
        return s;
    endfunction

    // what a slot looks like after an exception cancels it
    function automatic exec_data_t cancelled(exec_data_t s);
        exec_data_t c;
        c = s;
        c.valid = 1'b0;
        c.regwrite = 1'b0;
        c.op = NOP;
        return c;
    endfunction

    function automatic exception_t exc_of(exc_code_t code, word_t pc, word_t bad);
        exception_t e;
        e.code = code;
        e.pc = pc;
        e.badvaddr = bad;
        return e;
    endfunction

    function automatic word_t pick_addr(decoded_op_t op, word_t base);
        case (op)
            SB, LB, LBU: return base + $urandom_range(0, 3);
            SH, LH, LHU: return base + ($urandom_range(0, 1) << 1);
            default:     return base;
        endcase
    endfunction

    // little endian byte model
    function automatic word_t predict_load(decoded_op_t op, word_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       value;
        b = ref_mem[addr];
        value = '0;
        case (op)
            LB:  value = {{24{b[7]}}, b};
            LBU: value = {24'd0, b};
            LH: begin
                h = {ref_mem[addr + 1], b};
                value = {{16{h[15]}}, h};
            end
            LHU: begin
                h = {ref_mem[addr + 1], b};
                value = {16'd0, h};
            end
            default: begin
                value = {ref_mem[addr + 3], ref_mem[addr + 2], ref_mem[addr + 1], b};
            end
        endcase
        return value;
    endfunction

    function automatic void model_store(decoded_op_t op, word_t addr, word_t data);
        ref_mem[addr] = data[7:0];
        if (op != SB) begin
            ref_mem[addr + 1] = data[15:8];
        end
        if (op == SW) begin
            ref_mem[addr + 2] = data[23:16];
            ref_mem[addr + 3] = data[31:24];
        end
    endfunction

    task automatic compare_value(string name, logic [CW-1:0] got, logic [CW-1:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // present a pair until the stage takes it
    task automatic issue(exec_data_t s1, exec_data_t s0, commit_rec_t want, bit hold);
        int n;
        in_valid = 1'b1;
        in_slot1 = s1;
        in_slot0 = s0;
        want_q.push_back(want);
        n = 0;
        @(negedge clk);
        while (!in_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            timeout_errors++;
            $display("timeout: pair at pc %h was never accepted", s1.pc);
        end
        @(posedge clk);
        #1;
        if (!hold) begin
            in_valid = 1'b0;
        end
    endtask

    task automatic drain();
        commit_rec_t got;
        commit_rec_t want;
        int          n;
        while (want_q.size() > 0) begin
            want = want_q.pop_front();
            n = 0;
            while (seen_q.size() == 0 && n < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                n++;
            end
            if (seen_q.size() == 0) begin
                timeout_errors++;
                $display("timeout: no commit for pair at pc %h", want.s1.pc);
            end else begin
                got = seen_q.pop_front();
                compare_value("out_slot1", got.s1, want.s1);
                compare_value("out_slot0", got.s0, want.s0);
                compare_value("exception_valid", CW'(got.exc_v), CW'(want.exc_v));
                compare_value("exception_data", CW'(got.exc), CW'(want.exc));
                compare_value("is_eret", CW'(got.eret), CW'(want.eret));
                compare_value("redirect_pc", CW'(got.rpc), CW'(want.rpc));
            end
        end
    endtask

    initial begin
        word_t       pc;
        word_t       base;
        word_t       addr;
        word_t       data;
        exec_data_t  s1;
        exec_data_t  s0;
        exec_data_t  w1;
        exec_data_t  w0;
        decoded_op_t op;
        seed = $urandom(71506);
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_slot1 = '0;
        in_slot0 = '0;
        ext_int = '0;
        timer_interrupt = 1'b0;
        value_errors = 0;
        timeout_errors = 0;
        pc = 32'h0000_0100;
        for (int i = 0; i < RAM_WORDS * 4; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // plain alu pair
        s1 = make_slot(ALU, pc, $urandom, 32'h0);
        s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
        issue(s1, s0, record(s1, s0, 1'b0, '0, 1'b0, '0), 1'b0);
        drain();
        pc = pc + 8;

        // random store then every load width over the same word
        for (int i = 0; i < 8; i++) begin
            base = $urandom_range(0, RAM_WORDS - 1) << 2;
            op = store_ops[$urandom_range(0, 2)];
            addr = pick_addr(op, base);
            data = $urandom;
            s1 = make_slot(op, pc, addr, data);
            s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
            issue(s1, s0, record(s1, s0, 1'b0, '0, 1'b0, '0), 1'b0);
            model_store(op, addr, data);
            pc = pc + 8;
            for (int j = 0; j < 5; j++) begin
                addr = pick_addr(load_ops[j], base);
                s1 = make_slot(ALU, pc, $urandom, 32'h0);
                s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
                if (j % 2 == 0) begin
                    s1 = make_slot(load_ops[j], pc, addr, 32'h0);
                end else begin
                    s0 = make_slot(load_ops[j], pc + 4, addr, 32'h0);
                end
                w1 = s1;
                w0 = s0;
                if (j % 2 == 0) begin
                    w1.result = predict_load(load_ops[j], addr);
                end else begin
                    w0.result = predict_load(load_ops[j], addr);
                end
                issue(s1, s0, record(w1, w0, 1'b0, '0, 1'b0, '0), 1'b0);
                pc = pc + 8;
            end
            drain();
        end

        // misaligned accesses around a known word
        base = $urandom_range(0, RAM_WORDS - 1) << 2;
        data = $urandom;
        s1 = make_slot(SW, pc, base, data);
        s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
        issue(s1, s0, record(s1, s0, 1'b0, '0, 1'b0, '0), 1'b0);
        model_store(SW, base, data);
        pc = pc + 8;
        s1 = make_slot(LW, pc, base + 1, 32'h0);
        s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
        issue(s1, s0, record(cancelled(s1), '0, 1'b1, exc_of(EXC_ADEL, pc, base + 1),
                             1'b0, pc), 1'b0);
        pc = pc + 8;
        s1 = make_slot(ALU, pc, $urandom, 32'h0);
        s0 = make_slot(SH, pc + 4, base + 3, $urandom);
        issue(s1, s0, record(s1, cancelled(s0), 1'b1, exc_of(EXC_ADES, pc + 4, base + 3),
                             1'b0, pc + 4), 1'b0);
        pc = pc + 8;
        s1 = make_slot(SW, pc, base + 2, $urandom);
        s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
        issue(s1, s0, record(cancelled(s1), '0, 1'b1, exc_of(EXC_ADES, pc, base + 2),
                             1'b0, pc), 1'b0);
        pc = pc + 8;
        s1 = make_slot(LW, pc, base, 32'h0);
        s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
        w1 = s1;
        w1.result = predict_load(LW, base);
        issue(s1, s0, record(w1, s0, 1'b0, '0, 1'b0, '0), 1'b0);
        drain();
        pc = pc + 8;

        // external interrupt lands on slot 1
        ext_int = 6'b000100;
        s1 = make_slot(ALU, pc, $urandom, 32'h0);
        s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
        issue(s1, s0, record(cancelled(s1), '0, 1'b1, exc_of(EXC_INT, pc, '0), 1'b0, pc),
              1'b0);
        drain();
        ext_int = '0;
        pc = pc + 8;

        // timer interrupt with only slot 0 valid
        timer_interrupt = 1'b1;
        s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
        issue('0, s0, record('0, cancelled(s0), 1'b1, exc_of(EXC_INT, pc + 4, '0), 1'b0,
                             pc + 4), 1'b0);
        drain();
        timer_interrupt = 1'b0;
        pc = pc + 8;

        s1 = make_slot(ALU, pc, $urandom, 32'h0);
        s0 = make_slot(SYSCALL, pc + 4, 32'h0, 32'h0);
        issue(s1, s0, record(s1, cancelled(s0), 1'b1, exc_of(EXC_SYS, pc + 4, '0), 1'b0,
                             pc + 4), 1'b0);
        pc = pc + 8;

        // eret drops the store behind it
        s1 = make_slot(ERET, pc, 32'h0, 32'h0);
        s0 = make_slot(SW, pc + 4, base, ~data);
        issue(s1, s0, record(s1, '0, 1'b0, '0, 1'b1, s1.epc), 1'b0);
        pc = pc + 8;
        s1 = make_slot(LW, pc, base, 32'h0);
        s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
        w1 = s1;
        w1.result = predict_load(LW, base);
        issue(s1, s0, record(w1, s0, 1'b0, '0, 1'b0, '0), 1'b0);
        drain();
        pc = pc + 8;

        // in_valid stays high across a mixed stream
        for (int k = 0; k < 9; k++) begin
            base = $urandom_range(0, 3) << 2;
            s1 = make_slot(ALU, pc, $urandom, 32'h0);
            s0 = make_slot(ALU, pc + 4, $urandom, 32'h0);
            w0 = s0;
            if (k % 3 == 1) begin
                op = store_ops[$urandom_range(0, 2)];
                addr = pick_addr(op, base);
                data = $urandom;
                s1 = make_slot(op, pc, addr, data);
                model_store(op, addr, data);
            end else if (k % 3 == 2) begin
                op = load_ops[$urandom_range(0, 4)];
                addr = pick_addr(op, base);
                s0 = make_slot(op, pc + 4, addr, 32'h0);
                w0 = s0;
                w0.result = predict_load(op, addr);
            end
            issue(s1, s0, record(s1, w0, 1'b0, '0, 1'b0, '0), k < 8);
            pc = pc + 8;
        end
        drain();

        repeat (4) @(posedge clk);
        if (seen_q.size() != 0) begin
            value_errors++;
            $display("%0d commits arrived that were never issued", seen_q.size());
        end
        assert_errors = commit_top_i.commit_assert_i.fail_count;
        $display("value errors %0d, timeout errors %0d, assertion errors %0d",
                 value_errors, timeout_errors, assert_errors);
        if (value_errors + timeout_errors + assert_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: commit_top.sv
`timescale 1ns/1ps

module commit_top #(
    parameter int RAM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  mips_pkg::exec_data_t in_slot1,
    input  mips_pkg::exec_data_t in_slot0,
    input  logic [5:0]           ext_int,
    input  logic                 timer_interrupt,
    output logic                 in_ready,
    output logic                 commit_valid,
    output mips_pkg::exec_data_t out_slot1,
    output mips_pkg::exec_data_t out_slot0,
    output logic                 exception_valid,
    output mips_pkg::exception_t exception_data,
    output logic                 is_eret,
    output mips_pkg::word_t      redirect_pc
);
    import mips_pkg::*;

    exec_data_t  stage_slot1;
    exec_data_t  stage_slot0;
    exec_data_t  checked1;
    exec_data_t  checked0;
    exception_t  exc_data1;
    exception_t  exc_data0;
    logic        stage_full;
    logic        first_cycle;
    logic        finish;
    logic        exc_valid1;
    logic        exc_valid0;
    logic [1:0]  size1;
    logic [1:0]  size0;
    word_t       wdata1;
    word_t       wdata0;
    word_t       load_data;
    decoded_op_t op_sel;
    logic        dmem_en;
    logic        dmem_wt;
    word_t       dmem_addr;
    word_t       dmem_wd;
    logic [1:0]  dmem_size;
    word_t       dmem_rd;
    logic        dmem_data_ok;

    commit_stage_reg commit_stage_reg_i (
        .clk, .reset, .in_valid, .in_slot1, .in_slot0, .finish,
        .in_ready, .stage_slot1, .stage_slot0, .stage_full, .first_cycle
    );

    // slot 1 has no older instruction in the pair
    exception_checker exception_checker1 (
        .slot(stage_slot1), .older_valid(1'b0), .ext_int, .timer_interrupt,
        .exc_valid(exc_valid1), .exc_data(exc_data1), .checked(checked1)
    );

    exception_checker exception_checker0 (
        .slot(stage_slot0), .older_valid(stage_slot1.valid), .ext_int, .timer_interrupt,
        .exc_valid(exc_valid0), .exc_data(exc_data0), .checked(checked0)
    );

    writedata_format writedata_format1 (.slot(stage_slot1), .size(size1), .wdata(wdata1));
    writedata_format writedata_format0 (.slot(stage_slot0), .size(size0), .wdata(wdata0));

    readdata_format readdata_format_i (
        .rd(dmem_rd), .addr_low(dmem_addr[1:0]), .op(op_sel), .data(load_data)
    );

    commit commit_i (
        .clk, .reset, .stage_slot1, .stage_slot0, .stage_full, .first_cycle,
        .checked1, .checked0, .exc_valid1, .exc_data1, .exc_valid0, .exc_data0,
        .size1, .wdata1, .size0, .wdata0, .load_data, .dmem_rd, .dmem_data_ok,
        .finish, .dmem_en, .dmem_wt, .dmem_addr, .dmem_wd, .dmem_size, .op_sel,
        .commit_valid, .out_slot1, .out_slot0, .exception_valid, .exception_data,
        .is_eret, .redirect_pc
    );

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) data_ram_i (
        .clk, .reset, .dmem_en, .dmem_wt, .dmem_addr, .dmem_wd, .dmem_size,
        .dmem_rd, .dmem_data_ok
    );

endmodule

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            dmem_en,
    input  logic            dmem_wt,
    input  mips_pkg::word_t dmem_addr,
    input  mips_pkg::word_t dmem_wd,
    input  logic [1:0]      dmem_size,
    output mips_pkg::word_t dmem_rd,
    output logic            dmem_data_ok
);

    localparam int ADDR_W = $clog2(RAM_WORDS);

    logic [31:0]       mem [RAM_WORDS];
    logic [ADDR_W-1:0] idx;
    logic [3:0]        be;

    assign idx = dmem_addr[ADDR_W+1:2];

    // byte lanes touched by the access
    always_comb begin
        case (dmem_size)
            2'd0:    be = 4'b0001 << dmem_addr[1:0];
            2'd1:    be = dmem_addr[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (dmem_en & dmem_wt) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[idx][8*b +: 8] <= dmem_wd[8*b +: 8];
                end
            end
        end
    end

    // read data and ok both land one cycle after the enable
    always_ff @(posedge clk) begin
        if (dmem_en) begin
            dmem_rd <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dmem_data_ok <= 1'b0;
        end else begin
            dmem_data_ok <= dmem_en;
        end
    end

endmodule

// File: exception_checker.sv
`timescale 1ns/1ps

module exception_checker (
    input  mips_pkg::exec_data_t slot,
    input  logic                 older_valid,
    input  logic [5:0]           ext_int,
    input  logic                 timer_interrupt,
    output logic                 exc_valid,
    output mips_pkg::exception_t exc_data,
    output mips_pkg::exec_data_t checked
);
    import mips_pkg::*;

    logic misaligned;
    logic int_take;
    logic adel;
    logic ades;
    logic sys;

    always_comb begin
        case (slot.op)
            LW, SW:      misaligned = (slot.result[1:0] != 2'b00);
            LH, LHU, SH: misaligned = slot.result[0];
            default:     misaligned = 1'b0;
        endcase
    end

    // interrupt goes to the oldest valid instruction only
    assign int_take = slot.valid & ~older_valid & ((|ext_int) | timer_interrupt);
    assign adel = slot.valid & is_load(slot.op) & misaligned;
    assign ades = slot.valid & is_store(slot.op) & misaligned;
    assign sys = slot.valid & (slot.op == SYSCALL);

    assign exc_valid = int_take | adel | ades | sys;

    always_comb begin
        exc_data = '0;
        if (int_take) begin
            exc_data.code = EXC_INT;
        end else if (adel) begin
            exc_data.code = EXC_ADEL;
            exc_data.badvaddr = slot.result;
        end else if (ades) begin
            exc_data.code = EXC_ADES;
            exc_data.badvaddr = slot.result;
        end else if (sys) begin
            exc_data.code = EXC_SYS;
        end
        if (exc_valid) begin
            exc_data.pc = slot.pc;
        end
    end

    // cancelled slot keeps its fields but does nothing
    always_comb begin
        checked = slot;
        if (exc_valid) begin
            checked.valid = 1'b0;
            checked.regwrite = 1'b0;
            checked.op = NOP;
        end
    end

endmodule

// File: mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;

    // decoded operation carried by each executed instruction
    typedef enum logic [3:0] {
        NOP,
        ALU,
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB,
        ERET,
        SYSCALL
    } decoded_op_t;

    // cp0 cause codes used by this stage
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8
    } exc_code_t;

    typedef struct packed {
        logic        valid;
        decoded_op_t op;
        word_t       pc;
        // alu result, or effective address for loads and stores
        word_t       result;
        word_t       srcb;
        logic [4:0]  destreg;
        logic        regwrite;
        word_t       epc;
    } exec_data_t;

    typedef struct packed {
        exc_code_t code;
        word_t     pc;
        word_t     badvaddr;
    } exception_t;

    function automatic logic is_load(decoded_op_t op);
        return op inside {LW, LH, LHU, LB, LBU};
    endfunction

    function automatic logic is_store(decoded_op_t op);
        return op inside {SW, SH, SB};
    endfunction

    function automatic logic is_mem(decoded_op_t op);
        return is_load(op) | is_store(op);
    endfunction

endpackage

// File: readdata_format.sv
`timescale 1ns/1ps

module readdata_format (
    input  mips_pkg::word_t       rd,
    input  logic [1:0]            addr_low,
    input  mips_pkg::decoded_op_t op,
    output mips_pkg::word_t       data
);
    import mips_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    always_comb begin
        case (addr_low)
            2'd0:    lane_b = rd[7:0];
            2'd1:    lane_b = rd[15:8];
            2'd2:    lane_b = rd[23:16];
            default: lane_b = rd[31:24];
        endcase
    end

    // halfword alignment already checked upstream
    assign lane_h = addr_low[1] ? rd[31:16] : rd[15:0];

    always_comb begin
        case (op)
            LB:      data = {{24{lane_b[7]}}, lane_b};
            LBU:     data = {24'd0, lane_b};
            LH:      data = {{16{lane_h[15]}}, lane_h};
            LHU:     data = {16'd0, lane_h};
            default: data = rd;
        endcase
    end

endmodule

// File: sources.f
mips_pkg.sv
exception_checker.sv
writedata_format.sv
readdata_format.sv
commit.sv
commit_stage_reg.sv
data_ram.sv
commit_top.sv
commit_assert.sv
commit_tb.sv

// File: writedata_format.sv
`timescale 1ns/1ps

module writedata_format (
    input  mips_pkg::exec_data_t slot,
    output logic [1:0]           size,
    output mips_pkg::word_t      wdata
);
    import mips_pkg::*;

    // size code 0 byte, 1 halfword, 2 word
    always_comb begin
        case (slot.op)
            SB, LB, LBU: size = 2'd0;
            SH, LH, LHU: size = 2'd1;
            default:     size = 2'd2;
        endcase
    end

    // store data copied into every lane, ram picks lanes by byte enable
    always_comb begin
        case (slot.op)
            SB:      wdata = {4{slot.srcb[7:0]}};
            SH:      wdata = {2{slot.srcb[15:0]}};
            default: wdata = slot.srcb;
        endcase
    end

endmodule
